// File: fc_core.f
+incdir+.
fc_pkg.sv
fc_beat_if.sv
fc_delay_line.sv
signed_mul_pipe.sv
mac_array.sv
fc_output_stage.sv
fc_core.sv
tb_clock_gen.sv
tb_fc_core.sv

// File: Makefile
# Verilator build and run for the FC core testbench

VERILATOR ?= verilator
TOP       ?= tb_fc_core
FLIST     ?= fc_core.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb_fc_core.sv
// Self-checking FC core testbench run as the simulation top with directed and random vectors
`timescale 1ns/1ps
`default_nettype none

`include "fc_cfg.svh"

module tb_fc_core import fc_pkg::*; ();

  localparam int          RESET_CYCLES = 8;
  localparam int          LATENCY      = 10;
  localparam int          RAND_VECS    = 40;
  localparam int          DIR_VECS     = 13;
  localparam int          MAX_BEATS    = 16;
  localparam int          MAX_GAP      = 3;
  localparam int          TIMEOUT_CYCLES =
    RESET_CYCLES + (RAND_VECS + DIR_VECS) * (MAX_BEATS * (1 + MAX_GAP) + 20);
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  logic      clk;
  logic      rstn;
  logic      in_valid;
  logic      in_first;
  logic      in_last;
  act_t      in_feat;
  act_vec_t  in_weight;
  act_vec_t  in_bias;
  logic      out_valid;
  act_vec_t  out_data;
  lane_idx_t out_max_idx;

  logic [31:0] lfsr = 32'he7d9_1e57;
  int          cycle = 0;
  int          vectors_sent = 0;
  int          results_seen = 0;
  logic        armed = 1'b0;
  logic        exp_valid = 1'b0;
  act_vec_t    exp_data;
  lane_idx_t   exp_idx;
  int          run_acc [`FC_LANES];
  int          due_q [$];
  act_vec_t    exp_data_q [$];
  lane_idx_t   exp_idx_q [$];

  tb_clock_gen #(.half_period(5), .reset_cycles(RESET_CYCLES)) clk_gen_i (
    .clk  (clk),
    .rstn (rstn)
  );

  fc_core dut_i (
    .clk         (clk),
    .rstn        (rstn),
    .in_valid    (in_valid),
    .in_first    (in_first),
    .in_last     (in_last),
    .in_feat     (in_feat),
    .in_weight   (in_weight),
    .in_bias     (in_bias),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_max_idx (out_max_idx)
  );

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) lfsr = lfsr ^ LFSR_TAPS;
      val  = {val[30:0], lsb};
    end
    return val;
  endfunction

  // ReLU and divide by 64 with a clamp at the int8 ceiling
  function automatic act_t relu_quant(input int sum);
    int q;
    if (sum < 0) return act_t'(0);
    q = sum / (1 << `FC_QUANT_SHIFT);
    if (q > `FC_ACT_MAX) return act_t'(`FC_ACT_MAX);
    return act_t'(q);
  endfunction

  task automatic push_expected(input act_vec_t bias);
    act_vec_t  res;
    lane_idx_t best_idx;
    for (int l = 0; l < `FC_LANES; l++) begin
      res[l] = relu_quant(run_acc[l] + int'(bias[l]));
    end
    best_idx = '0;
    for (int l = 1; l < `FC_LANES; l++) begin
      if (res[l] > res[best_idx]) best_idx = lane_idx_t'(l);
    end
    exp_data_q.push_back(res);
    exp_idx_q.push_back(best_idx);
  endtask

  task automatic send_beat(input logic first, input logic last, input act_t feat,
                           input act_vec_t weight, input act_vec_t bias);
    @(posedge clk);
    #1;
    in_valid  = 1'b1;
    in_first  = first;
    in_last   = last;
    in_feat   = feat;
    in_weight = weight;
    in_bias   = bias;
    for (int l = 0; l < `FC_LANES; l++) begin
      run_acc[l] = (first ? 0 : run_acc[l]) + int'(feat) * int'(weight[l]);
    end
    if (last) begin
      push_expected(bias);
      due_q.push_back(cycle);
      vectors_sent++;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      in_first = 1'b0;
      in_last  = 1'b0;
    end
  endtask

  task automatic send_random_vector(input int n_beats, input logic gaps);
    act_t     feat;
    act_vec_t weight;
    act_vec_t bias;
    // A one-beat vector waits a cycle so two last beats never touch
    if (n_beats == 1) idle(1);
    for (int b = 0; b < n_beats; b++) begin
      feat   = act_t'(rand_bits(8));
      weight = act_vec_t'(rand_bits(32));
      bias   = act_vec_t'(rand_bits(32));
      send_beat(b == 0, b == n_beats - 1, feat, weight, bias);
      if (gaps) idle(int'(rand_bits(2)));
    end
  endtask

  ////////////////////////////////////////
  // Expected output timeline
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (!rstn) armed <= 1'b1;
    if (armed && out_valid) results_seen <= results_seen + 1;
    if (due_q.size() > 0 && due_q[0] + LATENCY == cycle + 1) begin
      exp_valid <= 1'b1;
      exp_data  <= exp_data_q.pop_front();
      exp_idx   <= exp_idx_q.pop_front();
      void'(due_q.pop_front());
    end else begin
      exp_valid <= 1'b0;
    end
    if (cycle >= TIMEOUT_CYCLES) begin
      report_fail($sformatf("Timeout: run not finished within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  assert property (@(posedge clk) (armed && !rstn) |-> !out_valid)
    else report_fail("out_valid was high while reset was asserted");

  assert property (@(posedge clk) armed |-> (out_valid == exp_valid))
    else report_fail($sformatf("Fail at %0t: out_valid %b, expected %b",
                               $time, $sampled(out_valid), $sampled(exp_valid)));

  assert property (@(posedge clk) (armed && out_valid) |-> (out_data == exp_data))
    else report_fail($sformatf("Fail at %0t: out_data %h, expected %h",
                               $time, $sampled(out_data), $sampled(exp_data)));

  assert property (@(posedge clk) (armed && out_valid) |-> (out_max_idx == exp_idx))
    else report_fail($sformatf("Fail at %0t: out_max_idx %0d, expected %0d",
                               $time, $sampled(out_max_idx), $sampled(exp_idx)));

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    in_valid  = 1'b0;
    in_first  = 1'b0;
    in_last   = 1'b0;
    in_feat   = '0;
    in_weight = '0;
    in_bias   = '0;
    wait (rstn);
    // Long positive run saturates every lane
    for (int b = 0; b < MAX_BEATS; b++) begin
      send_beat(b == 0, b == MAX_BEATS - 1, 8'sd127, {4{8'h7f}}, '0);
    end
    idle(2);
    // All lanes negative so ReLU gives zero and argmax falls to lane 0
    send_beat(1'b1, 1'b1, 8'sd127, {4{8'h80}}, {4{8'hff}});
    idle(1);
    // Operand extremes
    send_beat(1'b1, 1'b1, -8'sd128, 32'h7f80_7f80, 32'h7f80_0180);
    idle(3);
    // Lanes 1 and 2 tie
    send_beat(1'b1, 1'b1, 8'sd64, 32'h0102_0201, '0);
    // One-beat vectors a cycle apart and a short vector right after the last one
    for (int v = 0; v < 8; v++) begin
      send_random_vector(1, 1'b0);
    end
    send_random_vector(3, 1'b0);
    idle(1);
    for (int v = 0; v < RAND_VECS; v++) begin
      send_random_vector(int'(rand_bits(4)) + 1, 1'b1);
    end
    idle(1);
    while (results_seen != vectors_sent) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and synchronous reset source, instantiated once by the FC core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 5,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // Release just after an edge so the DUT sees a clean sample
  initial begin
    rstn = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1 rstn = 1'b1;
  end

endmodule

`default_nettype wire

// File: fc_core.sv
// Top level of the FC dot-product engine, instantiated by the testbench or a parent design
`timescale 1ns/1ps
`default_nettype none

module fc_core import fc_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      in_valid,
  input  logic      in_first,
  input  logic      in_last,
  input  act_t      in_feat,
  input  act_vec_t  in_weight,
  input  act_vec_t  in_bias,
  output logic      out_valid,
  output act_vec_t  out_data,
  output lane_idx_t out_max_idx
);

  logic     acc_valid;
  acc_vec_t acc;
  act_vec_t acc_bias;

  // Input beat bus
  fc_beat_if beat_bus ();

  assign beat_bus.valid  = in_valid;
  assign beat_bus.first  = in_first;
  assign beat_bus.last   = in_last;
  assign beat_bus.feat   = in_feat;
  assign beat_bus.weight = in_weight;
  assign beat_bus.bias   = in_bias;

  mac_array mac_i (
    .clk       (clk),
    .rstn      (rstn),
    .beat      (beat_bus.dst),
    .acc_valid (acc_valid),
    .acc       (acc),
    .bias      (acc_bias)
  );

  fc_output_stage out_i (
    .clk         (clk),
    .rstn        (rstn),
    .acc_valid   (acc_valid),
    .acc         (acc),
    .bias        (acc_bias),
    .out_valid   (out_valid),
    .out_data    (out_data),
    .out_max_idx (out_max_idx)
  );

endmodule

`default_nettype wire

// File: fc_output_stage.sv
// Bias add, ReLU, requantization and lane argmax on each finished vector, one register stage
`timescale 1ns/1ps
`default_nettype none

`include "fc_cfg.svh"

module fc_output_stage import fc_pkg::*; (
  input  logic      clk,
  input  logic      rstn,
  input  logic      acc_valid,
  input  acc_vec_t  acc,
  input  act_vec_t  bias,
  output logic      out_valid,
  output act_vec_t  out_data,
  output lane_idx_t out_max_idx
);

  acc_t      sum [`FC_LANES];
  acc_t      scaled [`FC_LANES];
  act_vec_t  res;
  act_t      best;
  lane_idx_t max_idx;

  always_comb begin
    for (int i = 0; i < `FC_LANES; i++) begin
      sum[i]    = acc[i] + acc_t'(bias[i]);
      scaled[i] = sum[i] >>> `FC_QUANT_SHIFT;
      // ReLU first, then clamp to the int8 ceiling
      if (sum[i] < 0) begin
        res[i] = '0;
      end else if (scaled[i] > `FC_ACT_MAX) begin
        res[i] = act_t'(`FC_ACT_MAX);
      end else begin
        res[i] = act_t'(scaled[i]);
      end
    end
    // Strict compare keeps the lowest index on ties
    best    = res[0];
    max_idx = '0;
    for (int i = 1; i < `FC_LANES; i++) begin
      if (res[i] > best) begin
        best    = res[i];
        max_idx = lane_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid   <= 1'b0;
      out_max_idx <= '0;
    end else begin
      out_valid <= acc_valid;
      if (acc_valid) begin
        out_max_idx <= max_idx;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc_valid) begin
      out_data <= res;
    end
  end

  // Results come as isolated strobes
  assert property (@(posedge clk) disable iff (!rstn) out_valid |=> !out_valid)
    else $error("fc_output_stage: out_valid high in consecutive cycles");

  for (genvar i = 0; i < `FC_LANES; i++) begin : g_range_chk
    assert property (@(posedge clk) disable iff (!rstn)
      out_valid |-> (out_data[i] >= 0) && (out_data[i] <= `FC_ACT_MAX))
      else $error("fc_output_stage: lane %0d outside 0..%0d", i, `FC_ACT_MAX);
  end

endmodule

`default_nettype wire

// File: mac_array.sv
// Four-lane multiply-accumulate array fed by the beat bus that reports one accumulator set per vector
`timescale 1ns/1ps
`default_nettype none

`include "fc_cfg.svh"

module mac_array import fc_pkg::*; (
  input  logic     clk,
  input  logic     rstn,
  fc_beat_if.dst   beat,
  output logic     acc_valid,
  output acc_vec_t acc,
  output act_vec_t bias
);

  beat_ctl_t ctl_in;
  beat_ctl_t ctl_al;
  prod_t     prod [`FC_LANES];
  acc_vec_t  acc_q;
  logic      last_q;

  // Framing flags are dropped on idle cycles
  always_comb begin
    ctl_in.valid = beat.valid;
    ctl_in.first = beat.valid & beat.first;
    ctl_in.last  = beat.valid & beat.last;
  end

  ////////////////////////////////////////
  // Multipliers with the feature shared by all lanes
  ////////////////////////////////////////

  for (genvar i = 0; i < `FC_LANES; i++) begin : g_lane
    signed_mul_pipe mul_i (
      .clk (clk),
      .a   (beat.feat),
      .b   (beat.weight[i]),
      .p   (prod[i])
    );
  end

  fc_delay_line #(
    .payload_t (beat_ctl_t),
    .depth     (`FC_MUL_STAGES)
  ) ctl_dly_i (
    .clk  (clk),
    .rstn (rstn),
    .d    (ctl_in),
    .q    (ctl_al)
  );

  // One extra stage so the biases line up with acc_valid
  fc_delay_line #(
    .payload_t (act_vec_t),
    .depth     (`FC_MUL_STAGES + 1)
  ) bias_dly_i (
    .clk  (clk),
    .rstn (rstn),
    .d    (beat.bias),
    .q    (bias)
  );

  ////////////////////////////////////////
  // Accumulators
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int i = 0; i < `FC_LANES; i++) begin
      if (ctl_al.valid) begin
        acc_q[i] <= ctl_al.first ? acc_t'(prod[i]) : acc_q[i] + acc_t'(prod[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      last_q <= 1'b0;
    end else begin
      last_q <= ctl_al.valid & ctl_al.last;
    end
  end

  assign acc_valid = last_q;
  assign acc       = acc_q;

  // The source raises first or last only on a real beat
  assert property (@(posedge clk) disable iff (!rstn)
    (beat.first || beat.last) |-> beat.valid)
    else $error("mac_array: first or last flag on the beat bus without valid");

endmodule

`default_nettype wire

// File: signed_mul_pipe.sv
// Eight-stage signed int8 multiplier, one operand pair per cycle, product after eight cycles
`timescale 1ns/1ps
`default_nettype none

module signed_mul_pipe import fc_pkg::*; (
  input  logic  clk,
  input  act_t  a,
  input  act_t  b,
  output prod_t p
);

  logic [7:0]  a_mag;
  logic [7:0]  b_mag;
  logic [7:0]  pp [8];
  logic [7:0]  pp_q [8];
  logic [6:0]  sign_sr;
  logic [5:0]  lo2 [4];
  logic [5:0]  lo2_q [4];
  logic [2:0]  hi2e_q [4];
  logic [3:0]  hi2o_q [4];
  logic [4:0]  hi3 [4];
  logic [9:0]  s3_q [4];
  logic [7:0]  lo4 [2];
  logic [7:0]  lo4_q [2];
  logic [2:0]  hi4e_q [2];
  logic [4:0]  hi4o_q [2];
  logic [4:0]  hi5 [2];
  logic [11:0] s5_q [2];
  logic [9:0]  lo6;
  logic [9:0]  lo6_q;
  logic [2:0]  hi6e_q;
  logic [6:0]  hi6o_q;
  logic [6:0]  hi7;
  logic [15:0] mag_q;
  prod_t       p_q;

  // Magnitudes, -128 maps to 128 unsigned
  assign a_mag = a[7] ? ~a + 8'd1 : a;
  assign b_mag = b[7] ? ~b + 8'd1 : b;

  always_comb begin
    // Stage 1 partial products
    for (int i = 0; i < 8; i++) begin
      pp[i] = b_mag[i] ? a_mag : 8'd0;
    end
    // Stage 2 low bits of each pair, odd row weighted by 2
    // Stage 3 high bits plus carry
    for (int j = 0; j < 4; j++) begin
      lo2[j] = pp_q[2*j][4:0] + {pp_q[2*j+1][3:0], 1'b0};
      hi3[j] = hi2e_q[j] + hi2o_q[j] + lo2_q[j][5];
    end
    // Stages 4 and 5 pair the sums at a shift of 2
    for (int k = 0; k < 2; k++) begin
      lo4[k] = s3_q[2*k][6:0] + {s3_q[2*k+1][4:0], 2'b00};
      hi5[k] = hi4e_q[k] + hi4o_q[k] + lo4_q[k][7];
    end
    // Stages 6 and 7 at a shift of 4
    lo6 = s5_q[0][8:0] + {s5_q[1][4:0], 4'b0000};
    hi7 = hi6e_q + hi6o_q + lo6_q[9];
  end

  always_ff @(posedge clk) begin
    sign_sr <= {sign_sr[5:0], a[7] ^ b[7]};
    pp_q    <= pp;
    for (int j = 0; j < 4; j++) begin
      lo2_q[j]  <= lo2[j];
      hi2e_q[j] <= pp_q[2*j][7:5];
      hi2o_q[j] <= pp_q[2*j+1][7:4];
      s3_q[j]   <= {hi3[j], lo2_q[j][4:0]};
    end
    for (int k = 0; k < 2; k++) begin
      lo4_q[k]  <= lo4[k];
      hi4e_q[k] <= s3_q[2*k][9:7];
      hi4o_q[k] <= s3_q[2*k+1][9:5];
      s5_q[k]   <= {hi5[k], lo4_q[k][6:0]};
    end
    lo6_q  <= lo6;
    hi6e_q <= s5_q[0][11:9];
    hi6o_q <= s5_q[1][11:5];
    mag_q  <= {hi7, lo6_q[8:0]};
    // Stage 8 puts the sign back
    if (sign_sr[6]) begin
      p_q <= ~mag_q + 16'd1;
    end else begin
      p_q <= mag_q;
    end
  end

  assign p = p_q;

endmodule

`default_nettype wire

// File: fc_delay_line.sv
// Fixed-depth shift register for any payload type, used to align flags and biases with products
`timescale 1ns/1ps
`default_nettype none

module fc_delay_line #(
  parameter type payload_t = logic,
  parameter int  depth     = 1
) (
  input  logic     clk,
  input  logic     rstn,
  input  payload_t d,
  output payload_t q
);

  payload_t stage_q [depth];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < depth; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d;
      for (int i = 1; i < depth; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  // Oldest entry leaves the line
  assign q = stage_q[depth-1];

endmodule

`default_nettype wire

// File: fc_beat_if.sv
// Input beat bus from the core top level into the MAC array, driven via src and read via dst
`timescale 1ns/1ps
`default_nettype none

interface fc_beat_if import fc_pkg::*; ();

  logic     valid;
  logic     first;
  logic     last;
  act_t     feat;
  act_vec_t weight;
  // Only meaningful on a beat flagged last
  act_vec_t bias;

  modport src (
    output valid, first, last, feat, weight, bias
  );

  modport dst (
    input valid, first, last, feat, weight, bias
  );

endinterface

`default_nettype wire

// File: fc_pkg.sv
// Shared data, vector and control types of the FC core, imported by RTL and testbench
`default_nettype none

`include "fc_cfg.svh"

package fc_pkg;

  // One int8 feature, weight, bias or output value
  typedef logic signed [`FC_DATA_W-1:0] act_t;

  // One value per output neuron
  typedef act_t [`FC_LANES-1:0] act_vec_t;

  // Full-precision product of two int8 values
  typedef logic signed [2*`FC_DATA_W-1:0] prod_t;

  typedef logic signed [`FC_ACC_W-1:0] acc_t;

  typedef acc_t [`FC_LANES-1:0] acc_vec_t;

  // Framing flags that travel alongside the data
  typedef struct packed {
    logic valid;
    logic first;
    logic last;
  } beat_ctl_t;

  typedef logic [$clog2(`FC_LANES)-1:0] lane_idx_t;

endpackage

`default_nettype wire

// File: fc_cfg.svh
// Sizing and quantization macros for the FC core, included by the package, RTL and testbench
`ifndef FC_CFG_SVH
`define FC_CFG_SVH

////////////////////////////////////////
// Array shape
////////////////////////////////////////

// Output neurons computed in parallel
`define FC_LANES        4

// Feature, weight, bias and output width
`define FC_DATA_W       8

// Accumulator width
`define FC_ACC_W        28

////////////////////////////////////////
// Pipeline and requantization
////////////////////////////////////////

`define FC_MUL_STAGES   8
`define FC_QUANT_SHIFT  6
`define FC_ACT_MAX      127

`endif
